/* common/rv_core_pkg.sv */
package rv_core_pkg;

    //////////////////////////////////////////////////
    // widths and reset values
    //////////////////////////////////////////////////
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [XLEN-1:0]             addr_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    localparam addr_t RESET_PC  = 32'h0000_0000;
    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////
    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // operand source in EX
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

/* verilog/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  stall_i,
    input  logic  redirect_i,
    input  addr_t redirect_pc_i,
    input  word_t rom_data_i,
    output addr_t rom_addr_o,
    output addr_t id_pc_o,
    output word_t id_instr_o
);

    addr_t pc_q;

    assign rom_addr_o = pc_q;

    // redirect beats stall, the wrong-path fetch is dropped
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            id_instr_o <= NOP_INSTR;
        end else if (redirect_i) begin
            pc_q       <= redirect_pc_i;
            id_instr_o <= NOP_INSTR;
        end else if (!stall_i) begin
            pc_q       <= pc_q + 32'd4;
            id_instr_o <= rom_data_i;
        end
    end

    // pc of the instruction in ID, only used for branch targets
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_pc_o <= pc_q;
        end
    end

endmodule

/* decode/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder import rv_core_pkg::*; (
    input  word_t    instr_i,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output reg_idx_t rd_o,
    output word_t    imm_o,
    output alu_op_e  alu_op_o,
    output logic     alu_src_imm_o,
    output logic     reg_write_o,
    output logic     mem_read_o,
    output logic     mem_write_o,
    output logic     branch_o,
    output logic     branch_ne_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       writes_rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd_o   = instr_i[11:7];

    // immediate formats
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};

    // x0 is never a destination
    assign reg_write_o = writes_rd && (rd_o != '0);

    // source indices stay zero when unused, so no false hazards
    always_comb begin
        rs1_o         = '0;
        rs2_o         = '0;
        imm_o         = '0;
        alu_op_o      = ALU_ADD;
        alu_src_imm_o = 1'b0;
        writes_rd     = 1'b0;
        mem_read_o    = 1'b0;
        mem_write_o   = 1'b0;
        branch_o      = 1'b0;
        branch_ne_o   = 1'b0;
        case (opcode)
            OP: begin
                if (funct7 == 7'b0000000) begin
                    writes_rd = 1'b1;
                    case (funct3)
                        3'b000:  alu_op_o = ALU_ADD;
                        3'b010:  alu_op_o = ALU_SLT;
                        3'b100:  alu_op_o = ALU_XOR;
                        3'b110:  alu_op_o = ALU_OR;
                        3'b111:  alu_op_o = ALU_AND;
                        default: writes_rd = 1'b0;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    writes_rd = 1'b1;
                    alu_op_o  = ALU_SUB;
                end
                if (writes_rd) begin
                    rs1_o = instr_i[19:15];
                    rs2_o = instr_i[24:20];
                end
            end
            OP_IMM: begin
                // addi only
                if (funct3 == 3'b000) begin
                    writes_rd     = 1'b1;
                    alu_src_imm_o = 1'b1;
                    rs1_o         = instr_i[19:15];
                    imm_o         = imm_i;
                end
            end
            LOAD: begin
                if (funct3 == 3'b010) begin
                    writes_rd     = 1'b1;
                    mem_read_o    = 1'b1;
                    alu_src_imm_o = 1'b1;
                    rs1_o         = instr_i[19:15];
                    imm_o         = imm_i;
                end
            end
            STORE: begin
                if (funct3 == 3'b010) begin
                    mem_write_o   = 1'b1;
                    alu_src_imm_o = 1'b1;
                    rs1_o         = instr_i[19:15];
                    rs2_o         = instr_i[24:20];
                    imm_o         = imm_s;
                end
            end
            BRANCH: begin
                // beq and bne
                if (funct3[2:1] == 2'b00) begin
                    branch_o    = 1'b1;
                    branch_ne_o = funct3[0];
                    alu_op_o    = ALU_SUB;
                    rs1_o       = instr_i[19:15];
                    rs2_o       = instr_i[24:20];
                    imm_o       = imm_b;
                end
            end
            LUI: begin
                writes_rd     = 1'b1;
                alu_src_imm_o = 1'b1;
                alu_op_o      = ALU_PASS_B;
                imm_o         = imm_u;
            end
            default: begin
            end
        endcase
    end

endmodule

/* decode/reg_file.sv */
`timescale 1ns/10ps

module reg_file import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t rd_i,
    input  logic     we_i,
    input  word_t    wd_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);

    word_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = rst_n_i && we_i && (rd_i != '0);

    // x0 cleared in reset and never written after
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            regs[0] <= '0;
        end else if (wr_en) begin
            regs[rd_i] <= wd_i;
        end
    end

    // writeback bypass so ID sees this cycle's result
    assign rs1_data_o = (wr_en && (rs1_i == rd_i)) ? wd_i : regs[rs1_i];
    assign rs2_data_o = (wr_en && (rs2_i == rd_i)) ? wd_i : regs[rs2_i];

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        (rs1_i == '0) |-> (rs1_data_o == '0));

endmodule

/* verilog/hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit import rv_core_pkg::*; (
    input  reg_idx_t ex_rs1_i,
    input  reg_idx_t ex_rs2_i,
    input  reg_idx_t id_rs1_i,
    input  reg_idx_t id_rs2_i,
    input  reg_idx_t ex_rd_i,
    input  reg_idx_t mem_rd_i,
    input  reg_idx_t wb_rd_i,
    input  logic     ex_mem_read_i,
    input  logic     mem_reg_write_i,
    input  logic     wb_reg_write_i,
    output fwd_sel_e fwd_a_o,
    output fwd_sel_e fwd_b_o,
    output logic     stall_o
);

    // the younger result in MEM wins over WB
    function automatic fwd_sel_e pick_src(reg_idx_t rs);
        if (rs != '0 && mem_reg_write_i && mem_rd_i == rs) begin
            return FWD_MEM;
        end else if (rs != '0 && wb_reg_write_i && wb_rd_i == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a_o = pick_src(ex_rs1_i);
        fwd_b_o = pick_src(ex_rs2_i);
    end

    ////////////////////////////////////////////////////
    // load-use, load data only exists after MEM
    ////////////////////////////////////////////////////
    assign stall_o = ex_mem_read_i && (ex_rd_i != '0) &&
                     ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stall_i,
    input  fwd_sel_e fwd_a_i,
    input  fwd_sel_e fwd_b_i,
    input  reg_idx_t id_rs1_i,
    input  reg_idx_t id_rs2_i,
    input  reg_idx_t id_rd_i,
    input  word_t    id_imm_i,
    input  alu_op_e  id_alu_op_i,
    input  logic     id_alu_src_imm_i,
    input  logic     id_reg_write_i,
    input  logic     id_mem_read_i,
    input  logic     id_mem_write_i,
    input  logic     id_branch_i,
    input  logic     id_branch_ne_i,
    input  word_t    id_rs1_data_i,
    input  word_t    id_rs2_data_i,
    input  addr_t    id_pc_i,
    input  word_t    wb_data_i,
    output reg_idx_t ex_rs1_o,
    output reg_idx_t ex_rs2_o,
    output reg_idx_t ex_rd_o,
    output logic     ex_mem_read_o,
    output reg_idx_t mem_rd_o,
    output logic     mem_reg_write_o,
    output logic     mem_mem_read_o,
    output word_t    mem_addr_o,
    output word_t    mem_wdata_o,
    output logic     mem_we_o,
    output logic     redirect_o,
    output addr_t    redirect_pc_o
);

    logic    ex_reg_write_q;
    logic    ex_mem_write_q;
    logic    ex_branch_q;
    logic    ex_branch_ne_q;
    alu_op_e ex_alu_op_q;
    logic    ex_alu_src_imm_q;
    word_t   ex_imm_q;
    word_t   ex_rs1_data_q;
    word_t   ex_rs2_data_q;
    addr_t   ex_pc_q;
    logic    bubble;
    word_t   op_a;
    word_t   op_b_reg;
    word_t   op_b;
    word_t   alu_res;

    assign bubble = stall_i || redirect_o;

    //////////////////////////////////////////////////
    // ID/EX
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i || bubble) begin
            ex_rs1_o       <= '0;
            ex_rs2_o       <= '0;
            ex_rd_o        <= '0;
            ex_reg_write_q <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_q <= 1'b0;
            ex_branch_q    <= 1'b0;
            ex_branch_ne_q <= 1'b0;
        end else begin
            ex_rs1_o       <= id_rs1_i;
            ex_rs2_o       <= id_rs2_i;
            ex_rd_o        <= id_rd_i;
            ex_reg_write_q <= id_reg_write_i;
            ex_mem_read_o  <= id_mem_read_i;
            ex_mem_write_q <= id_mem_write_i;
            ex_branch_q    <= id_branch_i;
            ex_branch_ne_q <= id_branch_ne_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op_q      <= id_alu_op_i;
        ex_alu_src_imm_q <= id_alu_src_imm_i;
        ex_imm_q         <= id_imm_i;
        ex_rs1_data_q    <= id_rs1_data_i;
        ex_rs2_data_q    <= id_rs2_data_i;
        ex_pc_q          <= id_pc_i;
    end

    // forwarding muxes
    always_comb begin
        case (fwd_a_i)
            FWD_MEM: op_a = mem_addr_o;
            FWD_WB:  op_a = wb_data_i;
            default: op_a = ex_rs1_data_q;
        endcase
        case (fwd_b_i)
            FWD_MEM: op_b_reg = mem_addr_o;
            FWD_WB:  op_b_reg = wb_data_i;
            default: op_b_reg = ex_rs2_data_q;
        endcase
    end

    assign op_b = ex_alu_src_imm_q ? ex_imm_q : op_b_reg;

    always_comb begin
        case (ex_alu_op_q)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // beq/bne resolve here, taken means flush IF/ID and ID/EX
    assign redirect_o    = ex_branch_q && ((op_a == op_b_reg) != ex_branch_ne_q);
    assign redirect_pc_o = ex_pc_q + ex_imm_q;

    //////////////////////////////////////////////////
    // EX/MEM
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_rd_o        <= '0;
            mem_reg_write_o <= 1'b0;
            mem_mem_read_o  <= 1'b0;
            mem_we_o        <= 1'b0;
        end else begin
            mem_rd_o        <= ex_rd_o;
            mem_reg_write_o <= ex_reg_write_q;
            mem_mem_read_o  <= ex_mem_read_o;
            mem_we_o        <= ex_mem_write_q;
        end
    end

    // alu result doubles as address and writeback value
    always_ff @(posedge clk) begin
        mem_addr_o  <= alu_res;
        mem_wdata_o <= op_b_reg;
    end

    // the load-use stall must keep a load in MEM off the forward path
    a_no_fwd_from_load: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_mem_read_o |-> (fwd_a_i != FWD_MEM) && (fwd_b_i != FWD_MEM));

endmodule

/* verilog/mem_wb_stage.sv */
`timescale 1ns/10ps

module mem_wb_stage import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t mem_rd_i,
    input  logic     mem_reg_write_i,
    input  logic     mem_mem_read_i,
    input  word_t    mem_alu_i,
    input  word_t    ram_rdata_i,
    output reg_idx_t wb_rd_o,
    output logic     wb_reg_write_o,
    output word_t    wb_data_o
);

    logic  wb_mem_read_q;
    word_t wb_alu_q;
    word_t wb_load_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_rd_o        <= '0;
            wb_reg_write_o <= 1'b0;
            wb_mem_read_q  <= 1'b0;
        end else begin
            wb_rd_o        <= mem_rd_i;
            wb_reg_write_o <= mem_reg_write_i;
            wb_mem_read_q  <= mem_mem_read_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_alu_q  <= mem_alu_i;
        wb_load_q <= ram_rdata_i;
    end

    // word loads only, no extension needed
    assign wb_data_o = wb_mem_read_q ? wb_load_q : wb_alu_q;

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/10ps

module rv_core import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    output addr_t rom_addr_o,
    input  word_t rom_data_i,
    output addr_t ram_addr_o,
    output word_t ram_wdata_o,
    output logic  ram_we_o,
    output logic  ram_re_o,
    input  word_t ram_rdata_i
);

    // IF/ID
    addr_t    id_pc;
    word_t    id_instr;
    logic     stall;
    logic     redirect;
    addr_t    redirect_pc;

    // decode outputs
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    word_t    dec_imm;
    alu_op_e  dec_alu_op;
    logic     dec_alu_src_imm;
    logic     dec_reg_write;
    logic     dec_mem_read;
    logic     dec_mem_write;
    logic     dec_branch;
    logic     dec_branch_ne;
    word_t    rs1_data;
    word_t    rs2_data;

    // hazard and writeback
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    reg_idx_t ex_rs1;
    reg_idx_t ex_rs2;
    reg_idx_t ex_rd;
    logic     ex_mem_read;
    reg_idx_t mem_rd;
    logic     mem_reg_write;
    reg_idx_t wb_rd;
    logic     wb_reg_write;
    word_t    wb_data;

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .rom_data_i    (rom_data_i),
        .rom_addr_o    (rom_addr_o),
        .id_pc_o       (id_pc),
        .id_instr_o    (id_instr)
    );

    inst_decoder u_decoder (
        .instr_i       (id_instr),
        .rs1_o         (dec_rs1),
        .rs2_o         (dec_rs2),
        .rd_o          (dec_rd),
        .imm_o         (dec_imm),
        .alu_op_o      (dec_alu_op),
        .alu_src_imm_o (dec_alu_src_imm),
        .reg_write_o   (dec_reg_write),
        .mem_read_o    (dec_mem_read),
        .mem_write_o   (dec_mem_write),
        .branch_o      (dec_branch),
        .branch_ne_o   (dec_branch_ne)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (dec_rs1),
        .rs2_i      (dec_rs2),
        .rd_i       (wb_rd),
        .we_i       (wb_reg_write),
        .wd_i       (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    hazard_unit u_hazard (
        .ex_rs1_i        (ex_rs1),
        .ex_rs2_i        (ex_rs2),
        .id_rs1_i        (dec_rs1),
        .id_rs2_i        (dec_rs2),
        .ex_rd_i         (ex_rd),
        .mem_rd_i        (mem_rd),
        .wb_rd_i         (wb_rd),
        .ex_mem_read_i   (ex_mem_read),
        .mem_reg_write_i (mem_reg_write),
        .wb_reg_write_i  (wb_reg_write),
        .fwd_a_o         (fwd_a),
        .fwd_b_o         (fwd_b),
        .stall_o         (stall)
    );

    // MEM stage drives the data memory ports directly
    execute_stage u_execute (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .stall_i          (stall),
        .fwd_a_i          (fwd_a),
        .fwd_b_i          (fwd_b),
        .id_rs1_i         (dec_rs1),
        .id_rs2_i         (dec_rs2),
        .id_rd_i          (dec_rd),
        .id_imm_i         (dec_imm),
        .id_alu_op_i      (dec_alu_op),
        .id_alu_src_imm_i (dec_alu_src_imm),
        .id_reg_write_i   (dec_reg_write),
        .id_mem_read_i    (dec_mem_read),
        .id_mem_write_i   (dec_mem_write),
        .id_branch_i      (dec_branch),
        .id_branch_ne_i   (dec_branch_ne),
        .id_rs1_data_i    (rs1_data),
        .id_rs2_data_i    (rs2_data),
        .id_pc_i          (id_pc),
        .wb_data_i        (wb_data),
        .ex_rs1_o         (ex_rs1),
        .ex_rs2_o         (ex_rs2),
        .ex_rd_o          (ex_rd),
        .ex_mem_read_o    (ex_mem_read),
        .mem_rd_o         (mem_rd),
        .mem_reg_write_o  (mem_reg_write),
        .mem_mem_read_o   (ram_re_o),
        .mem_addr_o       (ram_addr_o),
        .mem_wdata_o      (ram_wdata_o),
        .mem_we_o         (ram_we_o),
        .redirect_o       (redirect),
        .redirect_pc_o    (redirect_pc)
    );

    mem_wb_stage u_mem_wb (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .mem_rd_i        (mem_rd),
        .mem_reg_write_i (mem_reg_write),
        .mem_mem_read_i  (ram_re_o),
        .mem_alu_i       (ram_addr_o),
        .ram_rdata_i     (ram_rdata_i),
        .wb_rd_o         (wb_rd),
        .wb_reg_write_o  (wb_reg_write),
        .wb_data_o       (wb_data)
    );

endmodule

/* sim/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core import rv_core_pkg::*; ();

    localparam int    ROM_WORDS      = 256;
    localparam int    RAM_WORDS      = 256;
    localparam int    TIMEOUT_CYCLES = 500;
    localparam int    DRAIN_CYCLES   = 8;
    // last store of every program goes here
    localparam addr_t DONE_ADDR      = 32'h0000_03FC;
    localparam word_t RAM_FILL_BASE  = 32'hC0DE_0000;
    localparam string PATTERN_FILE   = "sim/rv_core_patterns.txt";

    logic  clk = 1'b0;
    logic  rst_n_i;
    addr_t rom_addr;
    word_t rom_data;
    addr_t ram_addr;
    word_t ram_wdata;
    logic  ram_we;
    logic  ram_re;
    word_t ram_rdata;

    word_t rom [ROM_WORDS];
    word_t ram [RAM_WORDS];
    addr_t exp_addr [$];
    word_t exp_data [$];

    int store_idx     = 0;
    bit done_seen     = 1'b0;
    int value_errs    = 0;
    int protocol_errs = 0;
    int run_errs      = 0;

    always #5 clk = ~clk;

    rv_core uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rom_addr_o  (rom_addr),
        .rom_data_i  (rom_data),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_we_o    (ram_we),
        .ram_re_o    (ram_re),
        .ram_rdata_i (ram_rdata)
    );

    //////////////////////////////////////////////////
    // memory models, word addressed
    //////////////////////////////////////////////////
    assign rom_data  = rom[rom_addr[9:2]];
    assign ram_rdata = ram[ram_addr[9:2]];

    // contents set up during reset, fill value carries the byte address
    always @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i] <= RAM_FILL_BASE | (word_t'(i) << 2);
            end
        end else if (ram_we) begin
            ram[ram_addr[9:2]] <= ram_wdata;
        end
    end

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // I lines fill the ROM, S lines build the expected store stream
    task automatic load_patterns();
        int    fd;
        int    n;
        int    line_no;
        int    rom_idx;
        string line;
        byte   kind;
        word_t instr;
        addr_t addr;
        word_t data;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = NOP_INSTR;
        end
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            run_errs++;
            $display("cannot open pattern file %s", PATTERN_FILE);
            return;
        end
        line_no = 0;
        rom_idx = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            kind = line.getc(0);
            case (kind)
                "I": begin
                    n = $sscanf(line, "I %h", instr);
                    if (n != 1 || rom_idx >= ROM_WORDS) begin
                        run_errs++;
                        $display("bad or excess instruction record on line %0d", line_no);
                    end else begin
                        rom[rom_idx] = instr;
                        rom_idx++;
                    end
                end
                "S": begin
                    n = $sscanf(line, "S %h %h", addr, data);
                    if (n != 2) begin
                        run_errs++;
                        $display("bad store record on line %0d", line_no);
                    end else begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(data);
                    end
                end
                "#", " ", "\t", "\n", "\r", 8'd0: begin
                end
                default: begin
                    run_errs++;
                    $display("unknown record type on line %0d", line_no);
                end
            endcase
        end
        $fclose(fd);
        if (rom_idx == 0 || exp_addr.size() == 0) begin
            run_errs++;
            $display("pattern file holds no program or no expected stores");
        end
    endtask

    //////////////////////////////////////////////////
    // store stream checker
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!rst_n_i) begin
            if (ram_we !== 1'b0) begin
                protocol_errs++;
                $display("store enable raised during reset at %0t", $time);
            end
            if (ram_re !== 1'b0) begin
                protocol_errs++;
                $display("load enable raised during reset at %0t", $time);
            end
        end else begin
            if ($isunknown({ram_we, ram_re})) begin
                protocol_errs++;
                $display("memory enables unknown at %0t", $time);
            end
            // one instruction in MEM, so never a load and a store at once
            if (ram_we === 1'b1 && ram_re === 1'b1) begin
                protocol_errs++;
                $display("load and store enables both high at %0t", $time);
            end
            if (ram_we === 1'b1) begin
                if (store_idx >= exp_addr.size()) begin
                    protocol_errs++;
                    $display("store to %h at %0t is beyond the expected list",
                             ram_addr, $time);
                end else begin
                    check_addr("ram_addr_o", ram_addr, exp_addr[store_idx]);
                    check_word("ram_wdata_o", ram_wdata, exp_data[store_idx]);
                end
                store_idx++;
                if (ram_addr == DONE_ADDR) begin
                    done_seen = 1'b1;
                end
            end
        end
    end

    initial begin
        int cycles;
        int total;
        rst_n_i = 1'b0;
        load_patterns();
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;

        cycles = 0;
        while (!done_seen && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!done_seen) begin
            run_errs++;
            $display("program never finished, no sentinel store in %0d cycles",
                     TIMEOUT_CYCLES);
        end else begin
            // a few more cycles so stray stores after the sentinel show up
            cycles = 0;
            while (cycles < DRAIN_CYCLES) begin
                @(posedge clk);
                cycles++;
            end
            if (store_idx < exp_addr.size()) begin
                run_errs++;
                $display("only %0d of %0d expected stores were seen",
                         store_idx, exp_addr.size());
            end
        end

        total = value_errs + protocol_errs + run_errs;
        $display("errors: value %0d, protocol %0d, run %0d, stores %0d of %0d",
                 value_errs, protocol_errs, run_errs, store_idx, exp_addr.size());
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* rv_core.f */
common/rv_core_pkg.sv
verilog/fetch_stage.sv
decode/inst_decoder.sv
decode/reg_file.sv
verilog/hazard_unit.sv
execute/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

/* Makefile */
# Verilator flow for the rv_core pipeline
# override any variable on the command line, e.g. make sim LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/rv_core_patterns.txt */
# I <instruction hex>                 program words, loaded into the ROM from address 0
# S <byte address hex> <data hex>     expected stores in order, the last one is the sentinel
# alu and immediates, forwarding at distance 1 and 2
I 00500093   # 00: addi x1, x0, 5
I FFD00113   # 04: addi x2, x0, -3
I 002081B3   # 08: add  x3, x1, x2
I 10302023   # 0c: sw   x3, 0x100(x0)
I 40208233   # 10: sub  x4, x1, x2
I 10402223   # 14: sw   x4, 0x104(x0)
I 0020F2B3   # 18: and  x5, x1, x2
I 0020E333   # 1c: or   x6, x1, x2
I 0020C3B3   # 20: xor  x7, x1, x2
I 10502423   # 24: sw   x5, 0x108(x0)
I 10602623   # 28: sw   x6, 0x10c(x0)
I 10702823   # 2c: sw   x7, 0x110(x0)
I 00112433   # 30: slt  x8, x2, x1
I 0020A4B3   # 34: slt  x9, x1, x2
I 10802A23   # 38: sw   x8, 0x114(x0)
I 10902C23   # 3c: sw   x9, 0x118(x0)
I 12345537   # 40: lui  x10, 0x12345
I 67850513   # 44: addi x10, x10, 0x678
I 10A02E23   # 48: sw   x10, 0x11c(x0)
# store-load round trip and load-use stalls
I 11C02583   # 4c: lw   x11, 0x11c(x0)
I 00158613   # 50: addi x12, x11, 1
I 12C02023   # 54: sw   x12, 0x120(x0)
I 18002683   # 58: lw   x13, 0x180(x0)
I 12D02223   # 5c: sw   x13, 0x124(x0)
# x0 stays zero
I 04D00013   # 60: addi x0, x0, 77
I 12002423   # 64: sw   x0, 0x128(x0)
# branches
I 00208463   # 68: beq  x1, x2, +8 (not taken)
I 12102623   # 6c: sw   x1, 0x12c(x0)
I 00500713   # 70: addi x14, x0, 5
I 00170663   # 74: beq  x14, x1, +12 (taken)
I 12E02823   # 78: sw   x14, 0x130(x0) skipped
I 12E02A23   # 7c: sw   x14, 0x134(x0) skipped
I 00209663   # 80: bne  x1, x2, +12 (taken)
I 12102C23   # 84: sw   x1, 0x138(x0) skipped
I 12102E23   # 88: sw   x1, 0x13c(x0) skipped
I 00E09463   # 8c: bne  x1, x14, +8 (not taken)
I 14E02023   # 90: sw   x14, 0x140(x0)
I 3E402E23   # 94: sw   x4, 0x3fc(x0) sentinel
# expected store stream
S 00000100 00000002   # 5 + -3
S 00000104 00000008   # 5 - -3
S 00000108 00000005   # 5 and -3
S 0000010C FFFFFFFD   # 5 or -3
S 00000110 FFFFFFF8   # 5 xor -3
S 00000114 00000001   # -3 < 5
S 00000118 00000000   # 5 < -3
S 0000011C 12345678   # lui plus addi
S 00000120 12345679   # loaded word plus 1
S 00000124 C0DE0180   # untouched ram word at 0x180
S 00000128 00000000   # x0
S 0000012C 00000005   # after untaken beq
S 00000140 00000005   # after untaken bne
S 000003FC 00000008   # sentinel
